/* riscv151_pkg.sv */
package riscv151_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU, MEM, PC4, CSR
    } wb_sel_e;

    // R view, also gives rs1/rs2/rd/funct3 for every format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;   // csr number for SYSTEM
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // S view, B immediates are scrambled into the same slots
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        u_type_t u;   // U and J share this view
    } inst_t;

    localparam logic [11:0] CSR_TOHOST = 12'h51e;

    // host address map
    localparam logic [31:0] IMEM_BASE = 32'h0000_0000;
    localparam logic [31:0] DMEM_BASE = 32'h1000_0000;
    localparam logic [31:0] CTRL_ADDR = 32'h2000_0000;  // bit 0 is run
    localparam logic [31:0] CSR_ADDR  = 32'h2000_0004;  // read only

endpackage

/* riscv151_if.sv */
`timescale 1ns/1ns

// decoded instruction handed from decode to execute in the same cycle
interface ex_bus_if;
    logic [31:0]           pc;
    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    logic [4:0]            rd_addr;
    logic [31:0]           rs1_data;
    logic [31:0]           rs2_data;
    logic [31:0]           imm;
    riscv151_pkg::alu_op_e alu_op;
    logic                  use_imm;
    logic                  mem_we;
    logic                  mem_re;
    logic                  is_branch;
    logic                  branch_ne;   // bne when set, beq otherwise
    logic                  is_jal;
    logic                  csr_we;
    logic                  rd_we;
    riscv151_pkg::wb_sel_e wb_sel;

    modport dec (
        output pc, rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, imm, alu_op,
        output use_imm, mem_we, mem_re, is_branch, branch_ne, is_jal, csr_we, rd_we, wb_sel
    );

    modport exe (
        input pc, rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, imm, alu_op,
        input use_imm, mem_we, mem_re, is_branch, branch_ne, is_jal, csr_we, rd_we, wb_sel
    );
endinterface

/* fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit #(
    parameter logic [31:0] RESET_PC    = 32'h0000_0000,
    parameter int          IMEM_AWIDTH = 10
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   run_i,
    input  logic                   redirect_i,
    input  logic [31:0]            target_i,
    input  logic                   imem_we_i,
    input  logic [IMEM_AWIDTH-1:0] imem_addr_i,
    input  logic [31:0]            imem_wdata_i,
    output riscv151_pkg::inst_t    inst_o,
    output logic [31:0]            pc_o,
    output logic                   valid_o
);
    logic [31:0] imem [2**IMEM_AWIDTH];
    logic [31:0] fetch_pc;   // address of the word entering decode next

    always_ff @(posedge clk) begin
        if (reset_i || !run_i) begin
            fetch_pc <= RESET_PC;   // park at the start address while halted
            valid_o  <= 1'b0;
        end else begin
            fetch_pc <= redirect_i ? target_i : fetch_pc + 32'd4;
            // word read this cycle is the wrong path after a taken branch
            valid_o  <= !redirect_i;
        end
    end

    // host writes only land while halted
    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
        inst_o <= imem[fetch_pc[IMEM_AWIDTH+1:2]];
        pc_o   <= fetch_pc;
    end

endmodule

/* host_apb_port.sv */
`timescale 1ns/1ns

module host_apb_port #(
    parameter int IMEM_AWIDTH = 10,
    parameter int DMEM_AWIDTH = 10
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [31:0]            paddr_i,
    input  logic [31:0]            pwdata_i,
    output logic [31:0]            prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output logic                   run_o,
    output logic                   imem_we_o,
    output logic [IMEM_AWIDTH-1:0] imem_addr_o,
    output logic [31:0]            imem_wdata_o,
    output logic [DMEM_AWIDTH-1:0] dmem_addr_o,
    output logic                   dmem_we_o,
    output logic [31:0]            dmem_wdata_o,
    input  logic [31:0]            dmem_rdata_i,
    input  logic [31:0]            csr_i
);
    logic access;
    logic is_imem, is_dmem, is_ctrl, is_csr;

    assign access  = psel_i && penable_i;
    assign is_imem = (paddr_i >> (IMEM_AWIDTH + 2)) == (riscv151_pkg::IMEM_BASE >> (IMEM_AWIDTH + 2));
    assign is_dmem = (paddr_i >> (DMEM_AWIDTH + 2)) == (riscv151_pkg::DMEM_BASE >> (DMEM_AWIDTH + 2));
    assign is_ctrl = paddr_i == riscv151_pkg::CTRL_ADDR;
    assign is_csr  = paddr_i == riscv151_pkg::CSR_ADDR;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_o <= 1'b0;
        end else if (access && pwrite_i && is_ctrl) begin
            run_o <= pwdata_i[0];
        end
    end

    assign imem_we_o    = access && pwrite_i && is_imem && !run_o;
    assign imem_addr_o  = paddr_i[IMEM_AWIDTH+1:2];
    assign imem_wdata_o = pwdata_i;

    // address already valid in setup, so read data is ready in access
    assign dmem_addr_o  = paddr_i[DMEM_AWIDTH+1:2];
    assign dmem_we_o    = access && pwrite_i && is_dmem;
    assign dmem_wdata_o = pwdata_i;

    always_comb begin
        prdata_o = 32'd0;   // imem is write only from the host
        if (is_dmem) prdata_o = dmem_rdata_i;
        if (is_ctrl) prdata_o = {31'd0, run_o};
        if (is_csr)  prdata_o = csr_i;
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = access && (!(is_imem || is_dmem || is_ctrl || is_csr)
                                  || (pwrite_i && is_csr)
                                  || (pwrite_i && is_imem && run_o));

endmodule

/* regfile.sv */
`timescale 1ns/1ns

module regfile (
    input  logic        clk,
    input  logic [4:0]  ra1_i,
    input  logic [4:0]  ra2_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o,
    input  logic        we_i,
    input  logic [4:0]  wa_i,
    input  logic [31:0] wd_i
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we_i && wa_i != 5'd0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // no write bypass here, execute forwards the writeback value
    assign rd1_o = (ra1_i == 5'd0) ? 32'd0 : regs[ra1_i];
    assign rd2_o = (ra2_i == 5'd0) ? 32'd0 : regs[ra2_i];

endmodule

/* decoder.sv */
`timescale 1ns/1ns

module decoder (
    input  riscv151_pkg::inst_t inst_i,
    input  logic [31:0]         pc_i,
    input  logic                valid_i,
    output logic [4:0]          rs1_addr_o,
    output logic [4:0]          rs2_addr_o,
    input  logic [31:0]         rs1_data_i,
    input  logic [31:0]         rs2_data_i,
    ex_bus_if.dec               bus
);
    logic [31:0]           imm_i, imm_s, imm_b, imm_u, imm_j;
    riscv151_pkg::alu_op_e arith_op;

    assign imm_i = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_s = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
    assign imm_b = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_lo[0], inst_i.s.imm_hi[5:0],
                    inst_i.s.imm_lo[4:1], 1'b0};
    assign imm_u = {inst_i.u.imm, 12'd0};
    assign imm_j = {{12{inst_i.u.imm[19]}}, inst_i.u.imm[7:0], inst_i.u.imm[8],
                    inst_i.u.imm[18:9], 1'b0};

    // funct3 shared by register and immediate forms, sub only for OP
    always_comb begin
        case (inst_i.r.funct3)
            3'b000: begin
                if (inst_i.r.opcode == riscv151_pkg::OP && inst_i.r.funct7[5]) begin
                    arith_op = riscv151_pkg::SUB;
                end else begin
                    arith_op = riscv151_pkg::ADD;
                end
            end
            3'b001:  arith_op = riscv151_pkg::SLL;
            3'b010:  arith_op = riscv151_pkg::SLT;
            3'b100:  arith_op = riscv151_pkg::XOR;
            3'b101:  arith_op = riscv151_pkg::SRL;
            3'b110:  arith_op = riscv151_pkg::OR;
            3'b111:  arith_op = riscv151_pkg::AND;
            default: arith_op = riscv151_pkg::ADD;
        endcase
    end

    assign rs1_addr_o   = inst_i.r.rs1;
    assign rs2_addr_o   = inst_i.r.rs2;
    assign bus.pc       = pc_i;
    assign bus.rs1_addr = inst_i.r.rs1;
    assign bus.rs2_addr = inst_i.r.rs2;
    assign bus.rd_addr  = inst_i.r.rd;
    assign bus.rs1_data = rs1_data_i;
    assign bus.rs2_data = rs2_data_i;

    always_comb begin
        // defaults form a bubble
        bus.imm       = imm_i;
        bus.alu_op    = riscv151_pkg::ADD;
        bus.use_imm   = 1'b0;
        bus.mem_we    = 1'b0;
        bus.mem_re    = 1'b0;
        bus.is_branch = 1'b0;
        bus.branch_ne = inst_i.r.funct3[0];
        bus.is_jal    = 1'b0;
        bus.csr_we    = 1'b0;
        bus.rd_we     = 1'b0;
        bus.wb_sel    = riscv151_pkg::ALU;
        if (valid_i) begin
            case (inst_i.r.opcode)
                riscv151_pkg::OP: begin
                    bus.alu_op = arith_op;
                    bus.rd_we  = 1'b1;
                end
                riscv151_pkg::OP_IMM: begin
                    bus.alu_op  = arith_op;
                    bus.use_imm = 1'b1;
                    bus.rd_we   = 1'b1;
                end
                riscv151_pkg::LUI: begin
                    bus.imm     = imm_u;
                    bus.alu_op  = riscv151_pkg::PASS_B;
                    bus.use_imm = 1'b1;
                    bus.rd_we   = 1'b1;
                end
                riscv151_pkg::LOAD: begin   // lw, address is rs1 + imm
                    bus.use_imm = 1'b1;
                    bus.mem_re  = 1'b1;
                    bus.rd_we   = 1'b1;
                end
                riscv151_pkg::STORE: begin
                    bus.imm     = imm_s;
                    bus.use_imm = 1'b1;
                    bus.mem_we  = 1'b1;
                end
                riscv151_pkg::BRANCH: begin
                    bus.imm       = imm_b;
                    bus.is_branch = 1'b1;
                end
                riscv151_pkg::JAL: begin
                    bus.imm    = imm_j;
                    bus.is_jal = 1'b1;
                    bus.rd_we  = 1'b1;
                    bus.wb_sel = riscv151_pkg::PC4;
                end
                riscv151_pkg::SYSTEM: begin
                    // csrrw to tohost only, rs1 + 0 carries the new value
                    if (inst_i.r.funct3 == 3'b001 && inst_i.i.imm == riscv151_pkg::CSR_TOHOST) begin
                        bus.imm     = 32'd0;
                        bus.use_imm = 1'b1;
                        bus.csr_we  = 1'b1;
                        bus.rd_we   = 1'b1;
                        bus.wb_sel  = riscv151_pkg::CSR;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* execute.sv */
`timescale 1ns/1ns

module execute #(
    parameter int DMEM_AWIDTH = 10
) (
    input  logic                   clk,
    input  logic                   reset_i,
    ex_bus_if.exe                  bus,
    output logic                   redirect_o,
    output logic [31:0]            target_o,
    output logic [DMEM_AWIDTH-1:0] dmem_addr_o,
    output logic                   dmem_we_o,
    output logic [31:0]            dmem_wdata_o,
    input  logic [31:0]            dmem_rdata_i,
    output logic                   wb_we_o,
    output logic [4:0]             wb_addr_o,
    output logic [31:0]            wb_data_o,
    output logic [31:0]            csr_o
);
    logic [31:0]           op_a, op_b, rs2_val, alu_out;
    logic                  taken;
    logic [31:0]           wb_result_q;
    logic [31:0]           wb_pc4_q;
    riscv151_pkg::wb_sel_e wb_sel_q;
    logic                  wb_csr_we_q;

    // writeback result overrides a stale register read
    assign op_a    = (wb_we_o && wb_addr_o != 5'd0 && wb_addr_o == bus.rs1_addr) ?
                     wb_data_o : bus.rs1_data;
    assign rs2_val = (wb_we_o && wb_addr_o != 5'd0 && wb_addr_o == bus.rs2_addr) ?
                     wb_data_o : bus.rs2_data;
    assign op_b    = bus.use_imm ? bus.imm : rs2_val;

    always_comb begin
        case (bus.alu_op)
            riscv151_pkg::ADD: alu_out = op_a + op_b;
            riscv151_pkg::SUB: alu_out = op_a - op_b;
            riscv151_pkg::AND: alu_out = op_a & op_b;
            riscv151_pkg::OR:  alu_out = op_a | op_b;
            riscv151_pkg::XOR: alu_out = op_a ^ op_b;
            riscv151_pkg::SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            riscv151_pkg::SLL: alu_out = op_a << op_b[4:0];
            riscv151_pkg::SRL: alu_out = op_a >> op_b[4:0];
            default:           alu_out = op_b;   // lui
        endcase
    end

    assign taken      = bus.is_branch && ((op_a == rs2_val) != bus.branch_ne);
    assign redirect_o = taken || bus.is_jal;
    assign target_o   = bus.pc + bus.imm;

    // word addressed, low two bits dropped
    assign dmem_addr_o  = alu_out[DMEM_AWIDTH+1:2];
    assign dmem_we_o    = bus.mem_we;
    assign dmem_wdata_o = rs2_val;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_we_o     <= 1'b0;
            wb_csr_we_q <= 1'b0;
            csr_o       <= 32'd0;
        end else begin
            wb_we_o     <= bus.rd_we;
            wb_csr_we_q <= bus.csr_we;
            if (wb_csr_we_q) begin
                csr_o <= wb_result_q;   // old value still goes to rd this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o   <= bus.rd_addr;
        wb_result_q <= alu_out;
        wb_pc4_q    <= bus.pc + 32'd4;
        wb_sel_q    <= bus.mem_re ? riscv151_pkg::MEM : bus.wb_sel;
    end

    always_comb begin
        case (wb_sel_q)
            riscv151_pkg::MEM: wb_data_o = dmem_rdata_i;   // sync read lands now
            riscv151_pkg::PC4: wb_data_o = wb_pc4_q;
            riscv151_pkg::CSR: wb_data_o = csr_o;
            default:           wb_data_o = wb_result_q;
        endcase
    end

endmodule

/* data_mem.sv */
`timescale 1ns/1ns

module data_mem #(
    parameter int DMEM_AWIDTH = 10
) (
    input  logic                   clk,
    input  logic [DMEM_AWIDTH-1:0] a_addr_i,   // core port
    input  logic                   a_we_i,
    input  logic [31:0]            a_wdata_i,
    output logic [31:0]            a_rdata_o,
    input  logic [DMEM_AWIDTH-1:0] b_addr_i,   // host port
    input  logic                   b_we_i,
    input  logic [31:0]            b_wdata_i,
    output logic [31:0]            b_rdata_o
);
    logic [31:0] ram [2**DMEM_AWIDTH];

    // write-first on both ports, host wins a same-address collision
    always_ff @(posedge clk) begin
        if (a_we_i) begin
            ram[a_addr_i] <= a_wdata_i;
            a_rdata_o     <= a_wdata_i;
        end else begin
            a_rdata_o <= ram[a_addr_i];
        end
        if (b_we_i) begin
            ram[b_addr_i] <= b_wdata_i;
            b_rdata_o     <= b_wdata_i;
        end else begin
            b_rdata_o <= ram[b_addr_i];
        end
    end

endmodule

/* riscv151.sv */
`timescale 1ns/1ns

module riscv151 #(
    parameter logic [31:0] RESET_PC    = 32'h0000_0000,
    parameter int          IMEM_AWIDTH = 10,
    parameter int          DMEM_AWIDTH = 10
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [31:0] paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic [31:0] csr_o
);
    logic                   run;
    logic                   imem_we;
    logic [IMEM_AWIDTH-1:0] imem_addr;
    logic [31:0]            imem_wdata;
    logic [DMEM_AWIDTH-1:0] host_addr, core_addr;
    logic                   host_we, core_we;
    logic [31:0]            host_wdata, host_rdata, core_wdata, core_rdata;
    riscv151_pkg::inst_t    inst;
    logic [31:0]            pc, target;
    logic                   valid, redirect;
    logic [4:0]             ra1, ra2, wb_addr;
    logic [31:0]            rd1, rd2, wb_data;
    logic                   wb_we;

    ex_bus_if ex_bus ();

    host_apb_port #(.IMEM_AWIDTH(IMEM_AWIDTH), .DMEM_AWIDTH(DMEM_AWIDTH)) host_i (
        .clk(clk), .reset_i(reset_i),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .run_o(run),
        .imem_we_o(imem_we), .imem_addr_o(imem_addr), .imem_wdata_o(imem_wdata),
        .dmem_addr_o(host_addr), .dmem_we_o(host_we), .dmem_wdata_o(host_wdata),
        .dmem_rdata_i(host_rdata),
        .csr_i(csr_o)
    );

    fetch_unit #(.RESET_PC(RESET_PC), .IMEM_AWIDTH(IMEM_AWIDTH)) fetch_i (
        .clk(clk), .reset_i(reset_i), .run_i(run),
        .redirect_i(redirect), .target_i(target),
        .imem_we_i(imem_we), .imem_addr_i(imem_addr), .imem_wdata_i(imem_wdata),
        .inst_o(inst), .pc_o(pc), .valid_o(valid)
    );

    decoder dec_i (
        .inst_i(inst), .pc_i(pc), .valid_i(valid),
        .rs1_addr_o(ra1), .rs2_addr_o(ra2),
        .rs1_data_i(rd1), .rs2_data_i(rd2),
        .bus(ex_bus)
    );

    regfile rf_i (
        .clk(clk),
        .ra1_i(ra1), .ra2_i(ra2), .rd1_o(rd1), .rd2_o(rd2),
        .we_i(wb_we), .wa_i(wb_addr), .wd_i(wb_data)
    );

    execute #(.DMEM_AWIDTH(DMEM_AWIDTH)) exe_i (
        .clk(clk), .reset_i(reset_i), .bus(ex_bus),
        .redirect_o(redirect), .target_o(target),
        .dmem_addr_o(core_addr), .dmem_we_o(core_we), .dmem_wdata_o(core_wdata),
        .dmem_rdata_i(core_rdata),
        .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data),
        .csr_o(csr_o)
    );

    data_mem #(.DMEM_AWIDTH(DMEM_AWIDTH)) dmem_i (
        .clk(clk),
        .a_addr_i(core_addr), .a_we_i(core_we), .a_wdata_i(core_wdata), .a_rdata_o(core_rdata),
        .b_addr_i(host_addr), .b_we_i(host_we), .b_wdata_i(host_wdata), .b_rdata_o(host_rdata)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_o
);
    initial clk_o = 1'b0;
    always #(PERIOD / 2) clk_o = ~clk_o;

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);   // release away from the active edge
        reset_o = 1'b0;
    end
endmodule

/* riscv151_tb.sv */
`timescale 1ns/1ns

module riscv151_tb;
    localparam int TIMEOUT = 2000;
    localparam int N_RANDOM = 8;

    logic        clk, reset_i;
    logic        psel, penable, pwrite;
    logic [31:0] paddr, pwdata, prdata, csr;
    logic        pready, pslverr;

    integer      seed;
    logic [31:0] rand_words [N_RANDOM];
    string       cur_test;
    logic        in_test;
    logic        aborted;
    int          test_errs, tests_run, tests_failed, total_errs;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(16)) clkgen_i (
        .clk_o(clk), .reset_o(reset_i)
    );

    riscv151 dut_i (
        .clk(clk), .reset_i(reset_i),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
        .csr_o(csr)
    );

    task automatic start_test(input string name);
        cur_test  = name;
        in_test   = 1'b1;
        test_errs = 0;
    endtask

    task automatic finish_test();
        total_errs += test_errs;   // errors outside any test count too
        if (in_test) begin
            tests_run++;
            if (test_errs != 0) tests_failed++;
            $display("test %0s: %0s (%0d errors)", cur_test,
                     (test_errs == 0) ? "ok" : "failing", test_errs);
            in_test = 1'b0;
        end
        test_errs = 0;
    endtask

    // one APB transfer, setup then access, ends once pready is seen
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waited;
        waited = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready && waited < TIMEOUT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!pready) begin
            $display("timeout: APB slave never became ready at address %h", addr);
            aborted = 1'b1;
        end
        rdata = prdata;   // combinational, settled well before the edge
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        assert (!err) else begin
            $display("%0s: unexpected slave error on write to %h", cur_test, addr);
            test_errs++;
        end
    endtask

    task automatic apb_read_check(input logic [31:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'd0, rd, err);
        assert (!err) else begin
            $display("%0s: unexpected slave error on read of %h", cur_test, addr);
            test_errs++;
        end
        assert (rd === exp) else begin
            $display("error %0s: addr %h expected %h actual %h", cur_test, addr, exp, rd);
            test_errs++;
        end
    endtask

    task automatic apb_expect_error(input logic [31:0] addr);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, 32'd0, rd, err);
        assert (err === 1'b1) else begin
            $display("%0s: write to %h was accepted without a slave error", cur_test, addr);
            test_errs++;
        end
    endtask

    task automatic wait_csr(input logic [31:0] exp);
        int waited;
        waited = 0;
        while (csr !== exp && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (csr === exp) else begin
            $display("timeout: csr output still %h, waiting for %h", csr, exp);
            test_errs++;
            aborted = 1'b1;
        end
    endtask

    // words come from the seed, so the expected copy is kept here
    task automatic random_round_trip();
        start_test("dmem_round_trip");
        for (int i = 0; i < N_RANDOM; i++) begin
            rand_words[i] = $random(seed);
            apb_write(32'h1000_0200 + 32'(4 * i), rand_words[i]);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            apb_read_check(32'h1000_0200 + 32'(4 * i), rand_words[i]);
        end
        finish_test();
    endtask

    initial begin
        integer           fd, code, waited;
        reg [8*128-1:0]   line;
        reg [8*8-1:0]     kind;
        reg [8*32-1:0]    name;
        logic [31:0]      a, d;

        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 32'd0;
        pwdata    = 32'd0;
        seed      = 32'h698d;
        in_test   = 1'b0;
        aborted   = 1'b0;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        total_errs   = 0;
        cur_test  = "none";

        waited = 0;
        while (reset_i !== 1'b0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (reset_i !== 1'b0) begin
            $display("timeout: reset was never released");
            aborted = 1'b1;
        end

        if (!aborted) random_round_trip();

        fd = $fopen("riscv151_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file riscv151_trace.txt");
            aborted = 1'b1;
        end

        while (!aborted && !$feof(fd)) begin
            line = 0;
            kind = 0;
            code = $fgets(line, fd);
            if (code > 0 && $sscanf(line, "%s", kind) == 1) begin
                if (kind == "T") begin
                    finish_test();
                    code = $sscanf(line, "%s %s", kind, name);
                    start_test($sformatf("%0s", name));
                end else if (kind == "W") begin
                    code = $sscanf(line, "%s %h %h", kind, a, d);
                    apb_write(a, d);
                end else if (kind == "R") begin
                    code = $sscanf(line, "%s %h %h", kind, a, d);
                    apb_read_check(a, d);
                end else if (kind == "E") begin
                    code = $sscanf(line, "%s %h", kind, a);
                    apb_expect_error(a);
                end else if (kind == "C") begin
                    code = $sscanf(line, "%s %h", kind, d);
                    wait_csr(d);
                end else if (kind != "#") begin
                    $display("unknown trace line: %0s", line);
                    test_errs++;
                end
            end
        end
        if (fd != 0) $fclose(fd);
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 total_errs);
        if (total_errs == 0 && !aborted) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end
endmodule

/* riscv151.f */
riscv151_pkg.sv
riscv151_if.sv
fetch_unit.sv
host_apb_port.sv
regfile.sv
decoder.sv
execute.sv
data_mem.sv
riscv151.sv
tb_clock_gen.sv
riscv151_tb.sv

/* Bender.yml */
package:
  name: riscv151

sources:
  - riscv151_pkg.sv
  - riscv151_if.sv
  - fetch_unit.sv
  - host_apb_port.sv
  - regfile.sv
  - decoder.sv
  - execute.sv
  - data_mem.sv
  - riscv151.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - riscv151_tb.sv

/* riscv151_trace.txt */
# W addr data = APB write, R addr expected = APB read and compare, E addr = write expecting pslverr
# C expected = wait for csr output, T name = start a test (all values hex)
T alu_lui
W 10000120 00000000
W 1000012c 00000000
W 10000130 00000000
W 00000000 123450b7
W 00000004 06400113
W 00000008 ff900193
W 0000000c 00310233
W 00000010 402182b3
W 00000014 00317333
W 00000018 0020e3b3
W 0000001c 0030c433
W 00000020 0021a4b3
W 00000024 00411513
W 00000028 01c1d593
W 0000002c 10402023
W 00000030 10502223
W 00000034 10602423
W 00000038 10702623
W 0000003c 10802823
W 00000040 10902a23
W 00000044 10a02c23
W 00000048 10b02e23
W 0000004c 00210463
W 00000050 12202023
W 00000054 00211463
W 00000058 12202223
W 0000005c 00310463
W 00000060 12302423
W 00000064 00311463
W 00000068 12202623
W 0000006c 0080066f
W 00000070 12202823
W 00000074 12c02a23
W 00000078 10002683
W 0000007c 00168713
W 00000080 00e707b3
W 00000084 12f02c23
W 00000088 00778833
W 0000008c 51e818f3
W 00000090 0000006f
W 20000000 00000001
C 12345120
R 10000100 0000005d
R 10000104 ffffff95
R 10000108 00000060
R 1000010c 12345064
R 10000110 edcbaff9
R 10000114 00000001
R 10000118 00000640
R 1000011c 0000000f
T control_flow
R 10000120 00000000
R 10000124 00000064
R 10000128 fffffff9
R 1000012c 00000000
R 10000130 00000000
R 10000134 00000070
T hazards
R 10000138 000000bc
T csr_output
C 12345120
R 20000004 12345120
T errors
E 30000000
E 20000004
E 00000000
